/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int    REG_COUNT = 32;
    localparam word_t RESET_PC  = 32'h1c000000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_MUL, ALU_MULH, ALU_MULHU
    } alu_op_e;

    // bits 31:26
    localparam logic [5:0] OP_FIELD_31_26_ALU    = 6'h00;
    localparam logic [5:0] OP_FIELD_31_26_LU12I  = 6'h05;
    // bits 25:22
    localparam logic [3:0] OP_FIELD_25_22_REG    = 4'h0;
    localparam logic [3:0] OP_FIELD_25_22_SHIFTI = 4'h1;
    localparam logic [3:0] OP_FIELD_25_22_SLTI   = 4'h8;
    localparam logic [3:0] OP_FIELD_25_22_SLTUI  = 4'h9;
    localparam logic [3:0] OP_FIELD_25_22_ADDI   = 4'ha;
    localparam logic [3:0] OP_FIELD_25_22_ANDI   = 4'hd;
    localparam logic [3:0] OP_FIELD_25_22_ORI    = 4'he;
    localparam logic [3:0] OP_FIELD_25_22_XORI   = 4'hf;
    // bits 21:20
    localparam logic [1:0] OP_FIELD_21_20_SHIFTI = 2'h0;
    localparam logic [1:0] OP_FIELD_21_20_REG    = 2'h1;
    // bits 19:15 for register forms
    localparam logic [4:0] OP_FIELD_19_15_ADD    = 5'h00;
    localparam logic [4:0] OP_FIELD_19_15_SUB    = 5'h02;
    localparam logic [4:0] OP_FIELD_19_15_SLT    = 5'h04;
    localparam logic [4:0] OP_FIELD_19_15_SLTU   = 5'h05;
    localparam logic [4:0] OP_FIELD_19_15_NOR    = 5'h08;
    localparam logic [4:0] OP_FIELD_19_15_AND    = 5'h09;
    localparam logic [4:0] OP_FIELD_19_15_OR     = 5'h0a;
    localparam logic [4:0] OP_FIELD_19_15_XOR    = 5'h0b;
    localparam logic [4:0] OP_FIELD_19_15_SLL    = 5'h0e;
    localparam logic [4:0] OP_FIELD_19_15_SRL    = 5'h0f;
    localparam logic [4:0] OP_FIELD_19_15_SRA    = 5'h10;
    localparam logic [4:0] OP_FIELD_19_15_MUL    = 5'h18;
    localparam logic [4:0] OP_FIELD_19_15_MULH   = 5'h19;
    localparam logic [4:0] OP_FIELD_19_15_MULHU  = 5'h1a;
    // bits 19:15 for shift immediates
    localparam logic [4:0] OP_FIELD_19_15_SLLI   = 5'h01;
    localparam logic [4:0] OP_FIELD_19_15_SRLI   = 5'h09;
    localparam logic [4:0] OP_FIELD_19_15_SRAI   = 5'h11;

endpackage

`default_nettype wire

/* verilog/pipe_if.sv */
`timescale 1ns/1ns
`default_nettype none

// decode to execute
interface exec_if;
    import core_pkg::*;

    logic      valid;
    alu_op_e   op;
    word_t     src1;
    word_t     src2;
    reg_addr_t dest;
    word_t     pc;

    modport decode  (output valid, op, src1, src2, dest, pc);
    modport execute (input  valid, op, src1, src2, dest, pc);
endinterface

// execute to result with a monitor view for decode
interface wb_if;
    import core_pkg::*;

    logic      valid;
    reg_addr_t dest;
    word_t     value;
    word_t     pc;

    modport execute (output valid, dest, value, pc);
    modport result  (input  valid, dest, value, pc);
    modport monitor (input  valid, dest, value);
endinterface

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire                 clk,
    input  core_pkg::reg_addr_t raddr1,
    output core_pkg::word_t     rdata1,
    input  core_pkg::reg_addr_t raddr2,
    output core_pkg::word_t     rdata2,
    input  wire                 we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata
);
    import core_pkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (we)
            regs[waddr] <= wdata;
    end

    // r0 always reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 inst_valid,
    input  core_pkg::word_t     inst,
    exec_if.decode              ex,
    wb_if.monitor               wb,
    input  wire                 rf_we,
    input  core_pkg::reg_addr_t rf_waddr,
    input  core_pkg::word_t     rf_wdata
);
    import core_pkg::*;

    logic      id_valid;
    word_t     id_inst;
    word_t     id_pc;
    word_t     fetch_pc;
    alu_op_e   op;
    logic      known;
    logic      use_imm;
    word_t     imm;
    reg_addr_t rj;
    reg_addr_t rk;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     rj_value;
    word_t     rk_value;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            id_valid <= 1'b0;
            fetch_pc <= RESET_PC;
        end
        else
        begin
            id_valid <= inst_valid;
            if (inst_valid)
                fetch_pc <= fetch_pc + 32'd4;
        end
    end

    always_ff @(posedge clk)
    begin
        if (inst_valid)
        begin
            id_inst <= inst;
            id_pc   <= fetch_pc;
        end
    end

    always_comb
    begin
        op      = ALU_ADD;
        known   = 1'b0;
        use_imm = 1'b0;
        imm     = {{20{id_inst[21]}}, id_inst[21:10]};
        if (id_inst[31:26] == OP_FIELD_31_26_ALU)
        begin
            case (id_inst[25:22])
                OP_FIELD_25_22_REG:
                begin
                    known = (id_inst[21:20] == OP_FIELD_21_20_REG);
                    case (id_inst[19:15])
                        OP_FIELD_19_15_ADD:   op = ALU_ADD;
                        OP_FIELD_19_15_SUB:   op = ALU_SUB;
                        OP_FIELD_19_15_SLT:   op = ALU_SLT;
                        OP_FIELD_19_15_SLTU:  op = ALU_SLTU;
                        OP_FIELD_19_15_NOR:   op = ALU_NOR;
                        OP_FIELD_19_15_AND:   op = ALU_AND;
                        OP_FIELD_19_15_OR:    op = ALU_OR;
                        OP_FIELD_19_15_XOR:   op = ALU_XOR;
                        OP_FIELD_19_15_SLL:   op = ALU_SLL;
                        OP_FIELD_19_15_SRL:   op = ALU_SRL;
                        OP_FIELD_19_15_SRA:   op = ALU_SRA;
                        OP_FIELD_19_15_MUL:   op = ALU_MUL;
                        OP_FIELD_19_15_MULH:  op = ALU_MULH;
                        OP_FIELD_19_15_MULHU: op = ALU_MULHU;
                        default:              known = 1'b0;
                    endcase
                end
                OP_FIELD_25_22_SHIFTI:
                begin
                    known   = (id_inst[21:20] == OP_FIELD_21_20_SHIFTI);
                    use_imm = 1'b1;
                    imm     = {27'b0, id_inst[14:10]};
                    case (id_inst[19:15])
                        OP_FIELD_19_15_SLLI: op = ALU_SLL;
                        OP_FIELD_19_15_SRLI: op = ALU_SRL;
                        OP_FIELD_19_15_SRAI: op = ALU_SRA;
                        default:             known = 1'b0;
                    endcase
                end
                OP_FIELD_25_22_SLTI,
                OP_FIELD_25_22_SLTUI,
                OP_FIELD_25_22_ADDI:
                begin
                    known   = 1'b1;
                    use_imm = 1'b1;
                    if (id_inst[25:22] == OP_FIELD_25_22_SLTI)
                        op = ALU_SLT;
                    else if (id_inst[25:22] == OP_FIELD_25_22_SLTUI)
                        op = ALU_SLTU;
                end
                OP_FIELD_25_22_ANDI,
                OP_FIELD_25_22_ORI,
                OP_FIELD_25_22_XORI:
                begin
                    known   = 1'b1;
                    use_imm = 1'b1;
                    // logical immediates are zero extended
                    imm     = {20'b0, id_inst[21:10]};
                    if (id_inst[25:22] == OP_FIELD_25_22_ANDI)
                        op = ALU_AND;
                    else if (id_inst[25:22] == OP_FIELD_25_22_ORI)
                        op = ALU_OR;
                    else
                        op = ALU_XOR;
                end
                default:
                    known = 1'b0;
            endcase
        end
        else if (id_inst[31:26] == OP_FIELD_31_26_LU12I && !id_inst[25])
        begin
            known   = 1'b1;
            use_imm = 1'b1;
            op      = ALU_LUI;
            imm     = {id_inst[24:5], 12'b0};
        end
    end

    assign rj = id_inst[9:5];
    assign rk = id_inst[14:10];

    reg_file reg_file_i (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rf_rdata1),
        .raddr2 (rk),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // newest producer wins over the register file
    assign rj_value = (wb.valid && wb.dest == rj && rj != '0) ? wb.value :
                      (rf_we && rf_waddr == rj && rj != '0)   ? rf_wdata : rf_rdata1;
    assign rk_value = (wb.valid && wb.dest == rk && rk != '0) ? wb.value :
                      (rf_we && rf_waddr == rk && rk != '0)   ? rf_wdata : rf_rdata2;

    assign ex.valid = id_valid && known;
    assign ex.op    = op;
    assign ex.src1  = rj_value;
    assign ex.src2  = use_imm ? imm : rk_value;
    assign ex.dest  = id_inst[4:0];
    assign ex.pc    = id_pc;

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  wire     clk,
    input  wire     reset,
    exec_if.execute ex,
    wb_if.execute   wb
);
    import core_pkg::*;

    logic               exe_valid;
    alu_op_e            exe_op;
    word_t              exe_src1;
    word_t              exe_src2;
    reg_addr_t          exe_dest;
    word_t              exe_pc;
    logic               mul_signed;
    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [65:0] product;
    word_t              result;

    always_ff @(posedge clk)
    begin
        if (reset)
            exe_valid <= 1'b0;
        else
            exe_valid <= ex.valid;
    end

    always_ff @(posedge clk)
    begin
        exe_op   <= ex.op;
        exe_src1 <= ex.src1;
        exe_src2 <= ex.src2;
        exe_dest <= ex.dest;
        exe_pc   <= ex.pc;
    end

    // one signed 33x33 multiplier covers both signednesses
    assign mul_signed = (exe_op != ALU_MULHU);
    assign mul_a      = {mul_signed & exe_src1[31], exe_src1};
    assign mul_b      = {mul_signed & exe_src2[31], exe_src2};
    assign product    = mul_a * mul_b;

    always_comb
    begin
        case (exe_op)
            ALU_ADD:   result = exe_src1 + exe_src2;
            ALU_SUB:   result = exe_src1 - exe_src2;
            ALU_SLT:   result = {31'b0, $signed(exe_src1) < $signed(exe_src2)};
            ALU_SLTU:  result = {31'b0, exe_src1 < exe_src2};
            ALU_AND:   result = exe_src1 & exe_src2;
            ALU_NOR:   result = ~(exe_src1 | exe_src2);
            ALU_OR:    result = exe_src1 | exe_src2;
            ALU_XOR:   result = exe_src1 ^ exe_src2;
            ALU_SLL:   result = exe_src1 << exe_src2[4:0];
            ALU_SRL:   result = exe_src1 >> exe_src2[4:0];
            ALU_SRA:   result = $signed(exe_src1) >>> exe_src2[4:0];
            ALU_LUI:   result = exe_src2;
            ALU_MUL:   result = product[31:0];
            default:   result = product[63:32];
        endcase
    end

    assign wb.valid = exe_valid;
    assign wb.dest  = exe_dest;
    assign wb.value = result;
    assign wb.pc    = exe_pc;

endmodule

`default_nettype wire

/* verilog/result_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module result_stage (
    input  wire                 clk,
    input  wire                 reset,
    wb_if.result                wb,
    output logic                rf_we,
    output core_pkg::reg_addr_t rf_waddr,
    output core_pkg::word_t     rf_wdata,
    output core_pkg::word_t     debug_wb_pc,
    output logic [3:0]          debug_wb_rf_we,
    output core_pkg::reg_addr_t debug_wb_rf_wnum,
    output core_pkg::word_t     debug_wb_rf_wdata
);
    import core_pkg::*;

    logic      res_valid;
    reg_addr_t res_dest;
    word_t     res_value;
    word_t     res_pc;

    always_ff @(posedge clk)
    begin
        if (reset)
            res_valid <= 1'b0;
        else
            res_valid <= wb.valid;
    end

    always_ff @(posedge clk)
    begin
        res_dest  <= wb.dest;
        res_value <= wb.value;
        res_pc    <= wb.pc;
    end

    // write port and trace share the same register
    assign rf_we             = res_valid;
    assign rf_waddr          = res_dest;
    assign rf_wdata          = res_value;
    assign debug_wb_pc       = res_pc;
    assign debug_wb_rf_we    = {4{res_valid}};
    assign debug_wb_rf_wnum  = res_dest;
    assign debug_wb_rf_wdata = res_value;

endmodule

`default_nettype wire

/* verilog/la_core.sv */
`timescale 1ns/1ns
`default_nettype none

module la_core (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 inst_valid,
    input  core_pkg::word_t     inst,
    output core_pkg::word_t     debug_wb_pc,
    output logic [3:0]          debug_wb_rf_we,
    output core_pkg::reg_addr_t debug_wb_rf_wnum,
    output core_pkg::word_t     debug_wb_rf_wdata
);
    import core_pkg::*;

    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    exec_if ex_bus ();
    wb_if   wb_bus ();

    decode_stage decode_i (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ex         (ex_bus),
        .wb         (wb_bus),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata)
    );

    execute_stage execute_i (
        .clk   (clk),
        .reset (reset),
        .ex    (ex_bus),
        .wb    (wb_bus)
    );

    result_stage result_i (
        .clk               (clk),
        .reset             (reset),
        .wb                (wb_bus),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

/* sim/core_props.sv */
`timescale 1ns/1ns
`default_nettype none

module core_props (
    input  wire             clk,
    input  wire             reset,
    input  core_pkg::word_t debug_wb_pc,
    input  wire [3:0]       debug_wb_rf_we
);
    import core_pkg::*;

    logic  seen_trace;
    word_t last_pc;

    // pc of the previous trace cycle
    always_ff @(posedge clk)
    begin
        if (reset)
            seen_trace <= 1'b0;
        else if (debug_wb_rf_we != 4'h0)
        begin
            seen_trace <= 1'b1;
            last_pc    <= debug_wb_pc;
        end
    end

    we_all_or_none: assert property (@(posedge clk)
        debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hf)
        else $error("trace write enable is neither all ones nor all zeros");

    we_low_in_reset: assert property (@(posedge clk)
        reset |=> debug_wb_rf_we == 4'h0)
        else $error("trace write enable high during reset");

    we_low_after_reset: assert property (@(posedge clk)
        $fell(reset) |=> debug_wb_rf_we == 4'h0)
        else $error("trace write enable high right after reset");

    first_pc: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_we != 4'h0 && !seen_trace) |-> debug_wb_pc == RESET_PC)
        else $error("first trace pc is not the reset pc");

    pc_step: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_we != 4'h0 && seen_trace) |-> debug_wb_pc == last_pc + 32'd4)
        else $error("trace pc did not advance by 4");

endmodule

bind la_core core_props props_i (
    .clk            (clk),
    .reset          (reset),
    .debug_wb_pc    (debug_wb_pc),
    .debug_wb_rf_we (debug_wb_rf_we)
);

`default_nettype wire

/* sim/core_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module core_checker (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 inst_valid,
    input  core_pkg::word_t     inst,
    input  core_pkg::word_t     debug_wb_pc,
    input  wire [3:0]           debug_wb_rf_we,
    input  core_pkg::reg_addr_t debug_wb_rf_wnum,
    input  core_pkg::word_t     debug_wb_rf_wdata,
    output int                  mismatches,
    output int                  other_errors,
    output int                  checks,
    output int                  pending
);
    import core_pkg::*;

    // edges from sampling an instruction to comparing its trace
    localparam int TRACE_DELAY = 3;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t dest;
        word_t     value;
    } trace_t;

    word_t  model_regs [REG_COUNT];
    word_t  model_pc;
    trace_t expected [$];

    function automatic word_t read_reg(input reg_addr_t r);
        return (r == '0) ? '0 : model_regs[r];
    endfunction

    // architectural result of one instruction
    task automatic execute_model(input word_t word, output logic known, output word_t value);
        word_t       a;
        word_t       b;
        word_t       si12;
        word_t       ui12;
        logic [63:0] prod_s;
        logic [63:0] prod_u;
        a      = read_reg(word[9:5]);
        b      = read_reg(word[14:10]);
        si12   = {{20{word[21]}}, word[21:10]};
        ui12   = {20'h0, word[21:10]};
        prod_s = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        prod_u = {32'h0, a} * {32'h0, b};
        known  = 1'b1;
        value  = '0;
        if (word[31:26] == OP_FIELD_31_26_LU12I && !word[25])
            value = {word[24:5], 12'h0};
        else if (word[31:26] != OP_FIELD_31_26_ALU)
            known = 1'b0;
        else if (word[25:22] == OP_FIELD_25_22_REG && word[21:20] == OP_FIELD_21_20_REG)
        begin
            case (word[19:15])
                OP_FIELD_19_15_ADD:   value = a + b;
                OP_FIELD_19_15_SUB:   value = a - b;
                OP_FIELD_19_15_SLT:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_FIELD_19_15_SLTU:  value = (a < b) ? 32'd1 : 32'd0;
                OP_FIELD_19_15_NOR:   value = ~(a | b);
                OP_FIELD_19_15_AND:   value = a & b;
                OP_FIELD_19_15_OR:    value = a | b;
                OP_FIELD_19_15_XOR:   value = a ^ b;
                OP_FIELD_19_15_SLL:   value = a << b[4:0];
                OP_FIELD_19_15_SRL:   value = a >> b[4:0];
                OP_FIELD_19_15_SRA:   value = $signed(a) >>> b[4:0];
                OP_FIELD_19_15_MUL:   value = prod_u[31:0];
                OP_FIELD_19_15_MULH:  value = prod_s[63:32];
                OP_FIELD_19_15_MULHU: value = prod_u[63:32];
                default:              known = 1'b0;
            endcase
        end
        else if (word[25:22] == OP_FIELD_25_22_SHIFTI && word[21:20] == OP_FIELD_21_20_SHIFTI)
        begin
            case (word[19:15])
                OP_FIELD_19_15_SLLI: value = a << word[14:10];
                OP_FIELD_19_15_SRLI: value = a >> word[14:10];
                OP_FIELD_19_15_SRAI: value = $signed(a) >>> word[14:10];
                default:             known = 1'b0;
            endcase
        end
        else
        begin
            case (word[25:22])
                OP_FIELD_25_22_SLTI:  value = ($signed(a) < $signed(si12)) ? 32'd1 : 32'd0;
                OP_FIELD_25_22_SLTUI: value = (a < si12) ? 32'd1 : 32'd0;
                OP_FIELD_25_22_ADDI:  value = a + si12;
                OP_FIELD_25_22_ANDI:  value = a & ui12;
                OP_FIELD_25_22_ORI:   value = a | ui12;
                OP_FIELD_25_22_XORI:  value = a ^ ui12;
                default:              known = 1'b0;
            endcase
        end
    endtask

    task automatic check_field(input string name, input word_t got, input word_t want);
        if (got !== want)
        begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic compare_trace(input trace_t entry);
        if (!entry.valid)
        begin
            if (debug_wb_rf_we != 4'h0)
            begin
                other_errors++;
                $display("trace write at pc %h with no instruction behind it", debug_wb_pc);
            end
        end
        else
        begin
            checks++;
            pending--;
            check_field("debug_wb_rf_we", {28'h0, debug_wb_rf_we}, 32'hf);
            check_field("debug_wb_pc", debug_wb_pc, entry.pc);
            check_field("debug_wb_rf_wnum", {27'h0, debug_wb_rf_wnum}, {27'h0, entry.dest});
            check_field("debug_wb_rf_wdata", debug_wb_rf_wdata, entry.value);
        end
    endtask

    always @(posedge clk)
    begin
        trace_t incoming;
        logic   known;
        word_t  value;
        if (reset)
        begin
            expected.delete();
            model_pc     = RESET_PC;
            mismatches   = 0;
            other_errors = 0;
            checks       = 0;
            pending      = 0;
            for (int i = 0; i < REG_COUNT; i++)
                model_regs[i] = '0;
        end
        else
        begin
            incoming = '0;
            if (inst_valid)
            begin
                execute_model(inst, known, value);
                incoming.valid = known;
                incoming.pc    = model_pc;
                incoming.dest  = inst[4:0];
                incoming.value = value;
                // r0 stays zero in the model
                if (known && inst[4:0] != '0)
                    model_regs[inst[4:0]] = value;
                if (known)
                    pending++;
                model_pc = model_pc + 32'd4;
            end
            expected.push_back(incoming);
            if (expected.size() > TRACE_DELAY)
                compare_trace(expected.pop_front());
            else if (debug_wb_rf_we != 4'h0)
            begin
                other_errors++;
                $display("trace write seen before any instruction could reach it");
            end
        end
    end

endmodule

`default_nettype wire

/* sim/core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam int SEED_COUNT   = 31;
    localparam int RANDOM_SLOTS = 2000;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = RANDOM_SLOTS + SEED_COUNT + RESET_CYCLES + 50;
    // kind numbers follow the case in encode
    localparam int KIND_COUNT   = 24;
    localparam int KIND_ADDI    = 19;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    word_t       inst;
    word_t       debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    reg_addr_t   debug_wb_rf_wnum;
    word_t       debug_wb_rf_wdata;
    int          mismatches;
    int          other_errors;
    int          checks;
    int          pending;
    int          sent;
    int          cycles;
    logic [31:0] rng_state;

    la_core dut_i (
        .clk               (clk),
        .reset             (reset),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    core_checker checker_i (
        .clk               (clk),
        .reset             (reset),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .mismatches        (mismatches),
        .other_errors      (other_errors),
        .checks            (checks),
        .pending           (pending)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r         = rng_state;
    endtask

    // half the picks land in r0-r7 so that dependencies come close together
    function automatic reg_addr_t pick_reg(input logic [7:0] b);
        return b[7] ? {2'b00, b[2:0]} : b[4:0];
    endfunction

    function automatic word_t encode(input int kind, input reg_addr_t rd, input reg_addr_t rj,
                                     input reg_addr_t rk, input logic [19:0] imm);
        logic [4:0] func;
        logic [3:0] major;
        word_t      word;
        func  = '0;
        major = '0;
        case (kind)
            0:  func = OP_FIELD_19_15_ADD;
            1:  func = OP_FIELD_19_15_SUB;
            2:  func = OP_FIELD_19_15_SLT;
            3:  func = OP_FIELD_19_15_SLTU;
            4:  func = OP_FIELD_19_15_NOR;
            5:  func = OP_FIELD_19_15_AND;
            6:  func = OP_FIELD_19_15_OR;
            7:  func = OP_FIELD_19_15_XOR;
            8:  func = OP_FIELD_19_15_SLL;
            9:  func = OP_FIELD_19_15_SRL;
            10: func = OP_FIELD_19_15_SRA;
            11: func = OP_FIELD_19_15_MUL;
            12: func = OP_FIELD_19_15_MULH;
            13: func = OP_FIELD_19_15_MULHU;
            14: func = OP_FIELD_19_15_SLLI;
            15: func = OP_FIELD_19_15_SRLI;
            16: func = OP_FIELD_19_15_SRAI;
            17: major = OP_FIELD_25_22_SLTI;
            18: major = OP_FIELD_25_22_SLTUI;
            19: major = OP_FIELD_25_22_ADDI;
            20: major = OP_FIELD_25_22_ANDI;
            21: major = OP_FIELD_25_22_ORI;
            22: major = OP_FIELD_25_22_XORI;
            default: major = '0;
        endcase
        if (kind < 14)
            word = {OP_FIELD_31_26_ALU, OP_FIELD_25_22_REG, OP_FIELD_21_20_REG, func, rk, rj, rd};
        else if (kind < 17)
            word = {OP_FIELD_31_26_ALU, OP_FIELD_25_22_SHIFTI, OP_FIELD_21_20_SHIFTI, func,
                    imm[4:0], rj, rd};
        else if (kind < 23)
            word = {OP_FIELD_31_26_ALU, major, imm[11:0], rj, rd};
        else
            word = {OP_FIELD_31_26_LU12I, 1'b0, imm, rd};
        return word;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        logic [31:0] r;
        reg_addr_t   rd;
        reg_addr_t   rj;
        reg_addr_t   rk;
        int          kind;
        rng_state  = 32'hd9ec8fb6;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        sent       = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // addi.w rN, r0, imm for every register
        for (int i = 1; i <= SEED_COUNT; i++)
        begin
            draw_random(r);
            inst_valid = 1'b1;
            inst       = encode(KIND_ADDI, reg_addr_t'(i), 5'd0, 5'd0, r[19:0]);
            sent++;
            @(posedge clk);
            #1;
        end
        for (int n = 0; n < RANDOM_SLOTS; n++)
        begin
            draw_random(r);
            inst_valid = (r[6:0] < 7'd102);
            kind       = int'(r[31:16] % 16'(KIND_COUNT));
            rd         = pick_reg(r[15:8]);
            draw_random(r);
            rj = pick_reg(r[7:0]);
            rk = pick_reg(r[15:8]);
            draw_random(r);
            inst = encode(kind, rd, rj, rk, r[19:0]);
            if (inst_valid)
                sent++;
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b0;
        inst       = '0;
        // drain the last traces
        while (pending != 0)
        begin
            @(posedge clk);
            #1;
        end
        if (checks != sent)
            $display("traces checked (%0d) differ from instructions sent (%0d)", checks, sent);
        $display("%0d instructions sent, %0d traces checked, %0d mismatches, %0d other errors",
                 sent, checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0 && checks == sent)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("%0d instructions sent, %0d traces checked, %0d mismatches, %0d other errors",
                 sent, checks, mismatches, other_errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
verilog/core_pkg.sv
verilog/pipe_if.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/la_core.sv
sim/core_props.sv
sim/core_checker.sv
sim/core_tb.sv

/* Makefile */
TOP := core_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build core_tb with Verilator, run it and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP) \
		-f list.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
